// File: verification/exec_cluster_vectors.txt
// group instr next_pc redirect target dest value burst (burst 1 = no gap after it)
// dest 00 means the instruction writes no register
1 24011234 00000000 0 00000000 01 00001234 0
1 2402fff0 00000000 0 00000000 02 fffffff0 0
1 3c038000 00000000 0 00000000 03 80000000 0
1 3424ff00 00000000 0 00000000 04 0000ff34 0
1 00222821 00000000 0 00000000 05 00001224 0
1 00223023 00000000 0 00000000 06 00001244 0
1 00813824 00000000 0 00000000 07 00001234 0
1 00814026 00000000 0 00000000 08 0000ed00 0
1 00014827 00000000 0 00000000 09 ffffedcb 0
1 0041502a 00000000 0 00000000 0a 00000001 0
1 286c0005 00000000 0 00000000 0c 00000001 0
1 2c2dffff 00000000 0 00000000 0d 00000001 0
1 304e8f0f 00000000 0 00000000 0e 00008f00 0
1 384f00ff 00000000 0 00000000 0f ffffff0f 0
2 00018100 00000000 0 00000000 10 00012340 1
2 00038a03 00000000 0 00000000 11 ff800000 1
2 24120007 00000000 0 00000000 12 00000007 0
2 00029f02 00000000 0 00000000 13 0000000f 0
3 0001a840 00000000 0 00000000 15 00002468 0
3 02b5b021 00000000 0 00000000 16 000048d0 0
3 26d50001 00000000 0 00000000 15 000048d1 0
3 0016b902 00000000 0 00000000 17 0000048d 1
3 26f70010 00000000 0 00000000 17 0000049d 0
4 08123456 40000008 1 4048d158 00 00000000 0
4 10210008 00001004 1 00001024 00 00000000 0
4 10220008 00001008 0 00000000 00 00000000 0
4 1422fffc 00002000 1 00001ff0 00 00000000 0
4 18400010 00003000 1 00003040 00 00000000 0
4 1c200020 00004000 1 00004080 00 00000000 0
4 1c600020 00004004 0 00000000 00 00000000 0
4 18000002 00005000 1 00005008 00 00000000 0
5 0001c080 00000000 0 00000000 18 000048d0 0
5 13160010 00006000 1 00006040 00 00000000 0
5 0003cfc3 00000000 0 00000000 19 ffffffff 0
5 1f200010 00007000 0 00000000 00 00000000 0
5 241a0005 00000000 0 00000000 1a 00000005 1
5 17400004 00008000 1 00008010 00 00000000 0
6 0001d8c0 00000000 0 00000000 1b 000091a0 1
6 0003e102 00000000 0 00000000 1c 08000000 1
6 0002e883 00000000 0 00000000 1d fffffffc 1
6 0002f200 00000000 0 00000000 1e fffff000 1
6 0001f842 00000000 0 00000000 1f 0000091a 1
6 001f8100 00000000 0 00000000 10 000091a0 1
6 00228826 00000000 0 00000000 11 ffffedc4 0

// File: all.f
rtl/core_pkg.sv
rtl/decode_control.sv
rtl/decode_stage.sv
rtl/issue_stage.sv
rtl/exec_unit.sv
rtl/writeback_collector.sv
rtl/exec_cluster_top.sv
verification/exec_cluster_properties.sv
verification/exec_cluster_tb.sv

// File: verification/exec_cluster_tb.sv
`timescale 1ns/100ps

module exec_cluster_tb import core_pkg::*; ();

    localparam int clock_period = 40;
    localparam int vec_words    = 8;
    localparam int max_vectors  = 64;
    localparam int wait_limit   = 200;
    localparam int drain_limit  = 500;

    logic              clock;
    logic              reset;
    logic              instr_valid;
    logic [31:0]       instr;
    logic [31:0]       next_pc;
    logic              stall;
    logic              redirect;
    logic [31:0]       redirect_target;
    logic              retire;
    logic [REG_AW-1:0] retire_dest;
    logic [31:0]       retire_value;

    // Per entry: group, instr, next_pc, redirect, target, dest, value, burst
    logic [31:0]       vectors [vec_words * max_vectors];
    int                exp_group [$];
    logic [REG_AW-1:0] exp_dest [$];
    logic [31:0]       exp_value [$];
    bit                stall_seen [8];
    int                vec_count;

    exec_cluster_top dut0 (
        .clock           (clock),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .next_pc         (next_pc),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .retire          (retire),
        .retire_dest     (retire_dest),
        .retire_value    (retire_value)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic string group_name(input int group);
        case (group)
            1:       return "alu_ops";
            2:       return "shift_order";
            3:       return "raw_waw";
            4:       return "branch_redirect";
            5:       return "branch_hold";
            6:       return "shift_burst";
            default: return "unknown";
        endcase
    endfunction

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // Oldest pending result for the retiring register
    task automatic check_retire();
        int idx;
        idx = -1;
        for (int i = 0; i < exp_dest.size(); i++) begin
            if (idx < 0 && exp_dest[i] == retire_dest) begin
                idx = i;
            end
        end
        assert (idx >= 0) else begin
            stop_on_failure($sformatf("Register r%0d retired with no result expected for it",
                                      retire_dest));
        end
        assert (retire_value == exp_value[idx]) else begin
            stop_on_failure($sformatf("[ERROR] %s: r%0d expected %08h actual %08h",
                                      group_name(exp_group[idx]), retire_dest,
                                      exp_value[idx], retire_value));
        end
        exp_group.delete(idx);
        exp_dest.delete(idx);
        exp_value.delete(idx);
    endtask

    // Retire only changes on the rising edge
    always @(negedge clock) begin
        if (reset && retire) begin
            check_retire();
        end
    end

    task automatic apply_vector(input int n);
        int                base;
        int                group;
        int                waited;
        logic [REG_AW-1:0] dest;
        base        = n * vec_words;
        group       = vectors[base];
        waited      = 0;
        instr_valid = 1'b1;
        instr       = vectors[base + 1];
        next_pc     = vectors[base + 2];
        #(clock_period / 4);
        while (stall) begin
            stall_seen[group] = 1'b1;
            waited++;
            assert (waited <= wait_limit) else begin
                stop_on_failure($sformatf("Instruction %08h was never accepted", instr));
            end
            @(negedge clock);
            #(clock_period / 4);
        end
        // Accepted at the coming rising edge
        assert (redirect == vectors[base + 3][0]) else begin
            stop_on_failure($sformatf("[ERROR] %s: redirect expected %0d actual %0d",
                                      group_name(group), vectors[base + 3][0], redirect));
        end
        if (vectors[base + 3][0]) begin
            assert (redirect_target == vectors[base + 4]) else begin
                stop_on_failure($sformatf("[ERROR] %s: target expected %08h actual %08h",
                                          group_name(group), vectors[base + 4],
                                          redirect_target));
            end
        end
        dest = vectors[base + 5][REG_AW-1:0];
        if (dest != '0) begin
            exp_group.push_back(group);
            exp_dest.push_back(dest);
            exp_value.push_back(vectors[base + 6]);
        end
    endtask

    initial begin
        int gap;
        int waited;
        void'($urandom(57203));
        reset       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        next_pc     = '0;
        $readmemh("verification/exec_cluster_vectors.txt", vectors);
        vec_count = 0;
        while (vec_count < max_vectors && !$isunknown(vectors[vec_count * vec_words + 1])) begin
            vec_count++;
        end
        assert (vec_count > 0) else begin
            stop_on_failure("No vectors could be read from the vector file");
        end

        repeat (2) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        for (int n = 0; n < vec_count; n++) begin
            apply_vector(n);
            @(negedge clock);
            gap = vectors[n * vec_words + 7][0] ? 0 : $urandom_range(0, 3);
            if (gap > 0) begin
                instr_valid = 1'b0;
                repeat (gap) @(negedge clock);
            end
        end
        instr_valid = 1'b0;

        assert (stall_seen[5]) else begin
            stop_on_failure("A branch with a busy operand did not raise stall");
        end
        assert (stall_seen[6]) else begin
            stop_on_failure("The shift burst never raised stall");
        end

        waited = 0;
        while (exp_dest.size() != 0 && waited < drain_limit) begin
            @(negedge clock);
            waited++;
        end
        if (exp_dest.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_on_failure($sformatf("Timed out with %0d results never retired",
                                      exp_dest.size()));
        end
    end

endmodule

// File: verification/exec_cluster_properties.sv
`timescale 1ns/100ps

module exec_cluster_properties import core_pkg::*; (
    input logic               clock,
    input logic               reset,
    input logic               instr_valid,
    input logic               stall,
    input logic               redirect,
    input logic               retire,
    input logic [REG_AW-1:0]  retire_dest,
    input logic [N_UNITS-1:0] disp
);

    // Register 0 never takes a write
    retire_dest_nonzero: assert property (
        @(posedge clock) disable iff (!reset) retire |-> retire_dest != '0
    ) else $error("retire reported for register 0");

    redirect_on_accept: assert property (
        @(posedge clock) disable iff (!reset) redirect |-> instr_valid && !stall
    ) else $error("redirect without an accepted instruction");

    single_dispatch: assert property (
        @(posedge clock) disable iff (!reset) $onehot0(disp)
    ) else $error("more than one unit dispatched in a cycle");

endmodule

bind exec_cluster_top exec_cluster_properties u_props (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .stall       (stall),
    .redirect    (redirect),
    .retire      (retire),
    .retire_dest (retire_dest),
    .disp        (disp)
);

// File: rtl/exec_cluster_top.sv
`timescale 1ns/100ps

module exec_cluster_top import core_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  logic [31:0]       next_pc,
    output logic              stall,
    output logic              redirect,
    output logic [31:0]       redirect_target,
    output logic              retire,
    output logic [REG_AW-1:0] retire_dest,
    output logic [31:0]       retire_value
);

    issue_packet_t      pkt;
    logic               pkt_valid;
    logic [REG_AW-1:0]  rs_addr;
    logic [REG_AW-1:0]  rt_addr;
    logic [31:0]        rs_data;
    logic [31:0]        rt_data;
    logic               rs_busy;
    logic               rt_busy;
    logic               iss_stall;
    logic [N_UNITS-1:0] disp;
    exec_op_t           disp_op;
    logic [N_UNITS-1:0] unit_busy;
    logic [N_UNITS-1:0] unit_done;
    exec_result_t       unit_result [N_UNITS];
    logic [N_UNITS-1:0] grant;
    logic               wb_en;
    logic [REG_AW-1:0]  wb_dest;
    logic [31:0]        wb_value;

    decode_stage u_decode (
        .clock           (clock),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .next_pc         (next_pc),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .rs_busy         (rs_busy),
        .rt_busy         (rt_busy),
        .iss_stall       (iss_stall),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .rs_addr         (rs_addr),
        .rt_addr         (rt_addr),
        .pkt_valid       (pkt_valid),
        .pkt             (pkt)
    );

    issue_stage u_issue (
        .clock     (clock),
        .reset     (reset),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .unit_busy (unit_busy),
        .wb_en     (wb_en),
        .wb_dest   (wb_dest),
        .wb_value  (wb_value),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .rs_busy   (rs_busy),
        .rt_busy   (rt_busy),
        .iss_stall (iss_stall),
        .disp      (disp),
        .disp_op   (disp_op)
    );

    // Dispatch op is shared; each unit latches it only on its own strobe
    for (genvar i = 0; i < N_UNITS; i++) begin : g_unit
        exec_unit u_exec (
            .clock  (clock),
            .reset  (reset),
            .disp   (disp[i]),
            .op     (disp_op),
            .grant  (grant[i]),
            .busy   (unit_busy[i]),
            .done   (unit_done[i]),
            .result (unit_result[i])
        );
    end

    writeback_collector u_collect (
        .clock    (clock),
        .reset    (reset),
        .done     (unit_done),
        .results  (unit_result),
        .grant    (grant),
        .wb_en    (wb_en),
        .wb_dest  (wb_dest),
        .wb_value (wb_value)
    );

    assign retire       = wb_en;
    assign retire_dest  = wb_dest;
    assign retire_value = wb_value;

endmodule

// File: rtl/writeback_collector.sv
`timescale 1ns/100ps

module writeback_collector import core_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic [N_UNITS-1:0] done,
    input  exec_result_t       results [N_UNITS],
    output logic [N_UNITS-1:0] grant,
    output logic               wb_en,
    output logic [REG_AW-1:0]  wb_dest,
    output logic [31:0]        wb_value
);

    logic [N_UNITS-1:0] pick;
    exec_result_t       chosen;
    logic               armed;

    // Lowest index wins
    always_comb begin
        pick   = '0;
        chosen = results[0];
        for (int i = N_UNITS - 1; i >= 0; i--) begin
            if (done[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
                chosen  = results[i];
            end
        end
    end

    // No write port activity before the first clock out of reset
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    assign grant    = armed ? pick : '0;
    assign wb_en    = armed && (|done);
    assign wb_dest  = chosen.dest;
    assign wb_value = chosen.value;

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit import core_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         disp,
    input  exec_op_t     op,
    input  logic         grant,
    output logic         busy,
    output logic         done,
    output exec_result_t result
);

    exec_op_t         op_q;
    logic [LAT_W-1:0] count;
    logic [31:0]      value;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (disp) begin
            busy  <= 1'b1;
            count <= op.is_shift ? LAT_W'(SHIFT_LATENCY - 1) : LAT_W'(ALU_LATENCY - 1);
        end else if (grant) begin
            busy <= 1'b0;
        end else if (busy && count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (disp) begin
            op_q <= op;
        end
    end

    assign done = busy && (count == '0);

    always_comb begin
        case (op_q.alu_op)
            alu_add:  value = op_q.opnd_a + op_q.opnd_b;
            alu_sub:  value = op_q.opnd_a - op_q.opnd_b;
            alu_and:  value = op_q.opnd_a & op_q.opnd_b;
            alu_or:   value = op_q.opnd_a | op_q.opnd_b;
            alu_xor:  value = op_q.opnd_a ^ op_q.opnd_b;
            alu_nor:  value = ~(op_q.opnd_a | op_q.opnd_b);
            alu_slt:  value = {31'b0, $signed(op_q.opnd_a) < $signed(op_q.opnd_b)};
            alu_sltu: value = {31'b0, op_q.opnd_a < op_q.opnd_b};
            alu_sll:  value = op_q.opnd_b << op_q.shamt;
            alu_srl:  value = op_q.opnd_b >> op_q.shamt;
            alu_sra:  value = $signed(op_q.opnd_b) >>> op_q.shamt;
            alu_lui:  value = op_q.opnd_b;  // already shifted up in decode
            default:  value = '0;
        endcase
    end

    assign result.dest  = op_q.dest;
    assign result.value = value;

endmodule

// File: rtl/issue_stage.sv
`timescale 1ns/100ps

module issue_stage import core_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic               pkt_valid,
    input  issue_packet_t      pkt,
    input  logic [REG_AW-1:0]  rs_addr,
    input  logic [REG_AW-1:0]  rt_addr,
    input  logic [N_UNITS-1:0] unit_busy,
    input  logic               wb_en,
    input  logic [REG_AW-1:0]  wb_dest,
    input  logic [31:0]        wb_value,
    output logic [31:0]        rs_data,
    output logic [31:0]        rt_data,
    output logic               rs_busy,
    output logic               rt_busy,
    output logic               iss_stall,
    output logic [N_UNITS-1:0] disp,
    output exec_op_t           disp_op
);

    logic [31:0]          regs [REG_COUNT];
    logic [REG_COUNT-1:0] busy_bits;
    logic [N_UNITS-1:0]   free_pick;
    logic                 any_free;
    logic                 src_ready;
    logic                 dispatch;

    // Register 0 is never written, so it reads zero and is never busy
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign rs_busy = busy_bits[rs_addr];
    assign rt_busy = busy_bits[rt_addr];

    // Lowest free unit
    always_comb begin
        free_pick = '0;
        for (int i = N_UNITS - 1; i >= 0; i--) begin
            if (!unit_busy[i]) begin
                free_pick    = '0;
                free_pick[i] = 1'b1;
            end
        end
    end

    assign any_free  = |free_pick;
    assign src_ready = !busy_bits[pkt.src_a] && (pkt.use_imm || !busy_bits[pkt.src_b]);
    assign dispatch  = pkt_valid && src_ready && !busy_bits[pkt.dest] && any_free;
    assign iss_stall = pkt_valid && !dispatch;
    assign disp      = dispatch ? free_pick : '0;

    always_comb begin
        disp_op          = '0;
        disp_op.alu_op   = pkt.alu_op;
        disp_op.is_shift = pkt.is_shift;
        disp_op.dest     = pkt.dest;
        disp_op.opnd_a   = regs[pkt.src_a];
        disp_op.opnd_b   = pkt.use_imm ? pkt.imm : regs[pkt.src_b];
        disp_op.shamt    = pkt.shamt;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (wb_en && wb_dest != '0) begin
            regs[wb_dest] <= wb_value;
        end
    end

    // Scoreboard: clear on writeback, set on dispatch
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy_bits <= '0;
        end else begin
            if (wb_en) begin
                busy_bits[wb_dest] <= 1'b0;
            end
            if (dispatch && pkt.writes_reg && pkt.dest != '0) begin
                busy_bits[pkt.dest] <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import core_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  logic [31:0]       next_pc,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    input  logic              rs_busy,
    input  logic              rt_busy,
    input  logic              iss_stall,
    output logic              stall,
    output logic              redirect,
    output logic [31:0]       redirect_target,
    output logic [REG_AW-1:0] rs_addr,
    output logic [REG_AW-1:0] rt_addr,
    output logic              pkt_valid,
    output issue_packet_t     pkt
);

    decoded_op_t       ctrl;
    logic [15:0]       imm16;
    logic [31:0]       imm_ext;
    logic [REG_AW-1:0] dest;
    logic              taken;
    logic              is_cond;
    logic              rs_hazard;
    logic              rt_hazard;
    logic              branch_hold;
    logic              accept;
    issue_packet_t     next_pkt;

    decode_control u_control (
        .op   (opcode_e'(instr[31:26])),
        .fn   (funct_e'(instr[5:0])),
        .ctrl (ctrl)
    );

    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign imm16   = instr[15:0];
    assign dest    = ctrl.dest_is_rd ? instr[15:11] : instr[20:16];

    always_comb begin
        if (ctrl.alu_op == alu_lui)
            imm_ext = {imm16, 16'h0000};
        else if (ctrl.zero_ext)
            imm_ext = {16'h0000, imm16};
        else
            imm_ext = {{16{imm16[15]}}, imm16};
    end

    // Branch comparator
    always_comb begin
        case (ctrl.cmp_kind)
            cmp_jump: taken = 1'b1;
            cmp_eq:   taken = (rs_data == rt_data);
            cmp_ne:   taken = (rs_data != rt_data);
            cmp_lez:  taken = ($signed(rs_data) <= 0);
            cmp_gtz:  taken = ($signed(rs_data) > 0);
            default:  taken = 1'b0;
        endcase
    end

    // A packet waiting in front has not marked its destination busy yet
    assign rs_hazard   = rs_busy || (pkt_valid && pkt.writes_reg && pkt.dest == rs_addr);
    assign rt_hazard   = rt_busy || (pkt_valid && pkt.writes_reg && pkt.dest == rt_addr);
    assign is_cond     = ctrl.cmp_kind inside {cmp_eq, cmp_ne, cmp_lez, cmp_gtz};
    assign branch_hold = instr_valid && is_cond &&
                         (rs_hazard || (ctrl.cmp_kind inside {cmp_eq, cmp_ne} && rt_hazard));

    assign stall    = iss_stall || branch_hold;
    assign accept   = instr_valid && !stall;
    assign redirect = accept && taken;

    assign redirect_target = (ctrl.cmp_kind == cmp_jump) ?
                             {next_pc[31:28], instr[25:0], 2'b00} :
                             next_pc + {imm_ext[29:0], 2'b00};

    always_comb begin
        next_pkt            = '0;
        next_pkt.alu_op     = ctrl.alu_op;
        next_pkt.is_shift   = ctrl.is_shift;
        next_pkt.use_imm    = ctrl.use_imm;
        next_pkt.writes_reg = ctrl.writes_reg && (dest != '0);
        next_pkt.dest       = dest;
        next_pkt.src_a      = rs_addr;
        next_pkt.src_b      = rt_addr;
        next_pkt.shamt      = instr[10:6];
        next_pkt.imm        = imm_ext;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pkt_valid <= 1'b0;
        end else if (!iss_stall) begin
            pkt_valid <= accept && next_pkt.writes_reg;
        end
    end

    always_ff @(posedge clock) begin
        if (!iss_stall) begin
            pkt <= next_pkt;
        end
    end

endmodule

// File: rtl/decode_control.sv
`timescale 1ns/100ps

module decode_control import core_pkg::*; (
    input  opcode_e     op,
    input  funct_e      fn,
    output decoded_op_t ctrl
);

    always_comb begin
        // Anything unrecognised falls through as a no-op
        ctrl          = '0;
        ctrl.alu_op   = alu_add;
        ctrl.cmp_kind = cmp_none;

        case (op)
            op_rtype: begin
                ctrl.dest_is_rd = 1'b1;
                ctrl.writes_reg = 1'b1;
                case (fn)
                    fn_sll: begin
                        ctrl.alu_op   = alu_sll;
                        ctrl.is_shift = 1'b1;
                    end
                    fn_srl: begin
                        ctrl.alu_op   = alu_srl;
                        ctrl.is_shift = 1'b1;
                    end
                    fn_sra: begin
                        ctrl.alu_op   = alu_sra;
                        ctrl.is_shift = 1'b1;
                    end
                    fn_addu: ctrl.alu_op = alu_add;
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_xor:  ctrl.alu_op = alu_xor;
                    fn_nor:  ctrl.alu_op = alu_nor;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    fn_sltu: ctrl.alu_op = alu_sltu;
                    default: ctrl.writes_reg = 1'b0;
                endcase
            end
            op_j:    ctrl.cmp_kind = cmp_jump;
            op_beq:  ctrl.cmp_kind = cmp_eq;
            op_bne:  ctrl.cmp_kind = cmp_ne;
            op_blez: ctrl.cmp_kind = cmp_lez;
            op_bgtz: ctrl.cmp_kind = cmp_gtz;
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                ctrl.use_imm    = 1'b1;
                ctrl.writes_reg = 1'b1;
                case (op)
                    op_slti:  ctrl.alu_op = alu_slt;
                    op_sltiu: ctrl.alu_op = alu_sltu;
                    op_andi:  ctrl.alu_op = alu_and;
                    op_ori:   ctrl.alu_op = alu_or;
                    op_xori:  ctrl.alu_op = alu_xor;
                    op_lui:   ctrl.alu_op = alu_lui;
                    default:  ctrl.alu_op = alu_add;
                endcase
                // Logical immediates take the upper half as zero
                ctrl.zero_ext = (op == op_andi) || (op == op_ori) || (op == op_xori);
            end
        endcase
    end

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    localparam int N_UNITS       = 4;
    localparam int REG_COUNT     = 32;
    localparam int REG_AW        = $clog2(REG_COUNT);
    localparam int ALU_LATENCY   = 1;
    localparam int SHIFT_LATENCY = 3;
    localparam int LAT_W         = $clog2(SHIFT_LATENCY + 1);

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_blez  = 6'h06,
        op_bgtz  = 6'h07,
        op_addiu = 6'h09,
        op_slti  = 6'h0a,
        op_sltiu = 6'h0b,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lui   = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        cmp_none, cmp_jump, cmp_eq, cmp_ne, cmp_lez, cmp_gtz
    } cmp_kind_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      zero_ext;
        logic      is_shift;
        logic      writes_reg;
        logic      dest_is_rd;
        cmp_kind_e cmp_kind;
    } decoded_op_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic              is_shift;
        logic              use_imm;
        logic              writes_reg;
        logic [REG_AW-1:0] dest;
        logic [REG_AW-1:0] src_a;
        logic [REG_AW-1:0] src_b;
        logic [4:0]        shamt;
        logic [31:0]       imm;
    } issue_packet_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic              is_shift;
        logic [REG_AW-1:0] dest;
        logic [31:0]       opnd_a;
        logic [31:0]       opnd_b;
        logic [4:0]        shamt;
    } exec_op_t;

    typedef struct packed {
        logic [REG_AW-1:0] dest;
        logic [31:0]       value;
    } exec_result_t;

endpackage
